// File: bench/icache_cases.txt
# operation  address  expected outcome (hit, miss, bypass; none for a flush)
# top nibble a is cached, a flush ignores its address
fetch a0000000 miss
fetch a0000004 hit
fetch a000000c hit
fetch a0000008 hit
fetch a0000010 miss
fetch a0000018 hit
fetch a0000000 hit
fetch 00001000 bypass
fetch 00001000 bypass
fetch 80000044 bypass
fetch a0000024 miss
fetch a0000020 hit
flush 00000000 none
fetch a0000004 miss
fetch a0000014 miss
fetch a0000024 miss
fetch a0000000 hit
fetch a0000030 miss
fetch a0000070 miss
fetch a0000034 miss
fetch a0000074 miss
fetch a0000038 miss
fetch a000003c hit
fetch b0000030 bypass
fetch a0000034 hit
fetch a0000ffc miss
fetch a0000ff0 hit
fetch 7ffffffc bypass

// File: filelist.f
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/icache_ctrl.sv
rtl/icache_perf.sv
rtl/icache_top.sv
bench/tb_clock_gen.sv
bench/bus_memory_model.sv
bench/icache_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module icache_tb \
		-Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/Vicache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: bench/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    localparam int LINE_WORDS_LOG2 = 2;
    localparam int LINE_WORDS      = 1 << LINE_WORDS_LOG2;
    localparam int LINE_BYTES      = 4 * LINE_WORDS;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_CASE = 400;
    localparam int HIT_LATENCY     = 2;
    localparam int STALL_SPREAD    = 4;
    localparam icache_pkg::word_t      DATA_MASK  = 32'h1234abcd;
    localparam icache_pkg::burst_len_t REFILL_LEN = 8'(LINE_WORDS - 1);
    localparam string CASES_FILE = "bench/icache_cases.txt";

    typedef enum logic [1:0] {
        outcome_hit,
        outcome_miss,
        outcome_bypass,
        outcome_none
    } outcome_t;

    logic                    clock;
    logic                    reset;
    logic                    flush;
    icache_pkg::fetch_req_t  fetch_req;
    logic                    fetch_req_ready;
    icache_pkg::fetch_rsp_t  fetch_rsp;
    logic                    fetch_rsp_ready;
    icache_pkg::bus_req_t    bus_req;
    logic                    bus_req_ready;
    icache_pkg::bus_rsp_t    bus_rsp;
    icache_pkg::perf_count_t hit_count;
    icache_pkg::perf_count_t miss_count;
    icache_pkg::perf_count_t bypass_count;

    // Operations from the cases file
    logic              case_is_flush [$];
    icache_pkg::addr_t case_addr [$];
    outcome_t          case_outcome [$];
    logic              cases_loaded;
    int                error_count;
    int                check_count;

    tb_clock_gen #(
        .HALF_PERIOD_NS (5),
        .RESET_CYCLES   (RESET_CYCLES)
    ) clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    bus_memory_model #(
        .SEED (16'd22)
    ) bus_memory_model_inst (
        .clock         (clock),
        .reset         (reset),
        .bus_req       (bus_req),
        .bus_req_ready (bus_req_ready),
        .bus_rsp       (bus_rsp)
    );

    icache_top #(
        .INDEX_WIDTH     (2),
        .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
    ) icache_top_inst (
        .clock           (clock),
        .reset           (reset),
        .flush           (flush),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .bus_req         (bus_req),
        .bus_req_ready   (bus_req_ready),
        .bus_rsp         (bus_rsp),
        .hit_count       (hit_count),
        .miss_count      (miss_count),
        .bypass_count    (bypass_count)
    );

    task automatic report_error(input string message);
        error_count++;
        $display("error at %0d ns: %s", $time, message);
    endtask

    // ------------------------------
    // Cases file
    // ------------------------------
    task automatic load_cases();
        int                fd;
        int                fields;
        string             line;
        string             op_text;
        string             outcome_text;
        icache_pkg::addr_t addr;
        outcome_t          outcome;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("could not open the cases file %s", CASES_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %s", op_text, addr, outcome_text);
            if (fields <= 0) begin
                continue;
            end
            if (fields != 3 || (op_text != "fetch" && op_text != "flush")) begin
                $display("malformed line in the cases file: %s", line);
                error_count++;
                continue;
            end
            if (outcome_text == "hit") begin
                outcome = outcome_hit;
            end else if (outcome_text == "miss") begin
                outcome = outcome_miss;
            end else if (outcome_text == "bypass") begin
                outcome = outcome_bypass;
            end else begin
                outcome = outcome_none;
            end
            case_is_flush.push_back(op_text == "flush");
            case_addr.push_back(addr);
            case_outcome.push_back(outcome);
        end
        $fclose(fd);
    endtask

    // Flush only between fetches, so the cache is idle
    task automatic apply_flush();
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        @(negedge clock);
    endtask

    // ------------------------------
    // One fetch, start and end on a falling edge
    // ------------------------------
    task automatic run_fetch(input int idx);
        icache_pkg::addr_t       addr;
        icache_pkg::word_t       expect_word;
        icache_pkg::word_t       first_word;
        icache_pkg::bus_req_t    seen_req;
        icache_pkg::perf_count_t hits_before;
        icache_pkg::perf_count_t misses_before;
        icache_pkg::perf_count_t bypasses_before;
        outcome_t                outcome;
        int                      cycle;
        int                      first_valid;
        int                      stall_left;
        int                      bus_requests;
        int                      busy_cycles;
        logic                    taken;

        addr            = case_addr[idx];
        outcome         = case_outcome[idx];
        expect_word     = {addr[31:2], 2'b00} ^ DATA_MASK;
        hits_before     = hit_count;
        misses_before   = miss_count;
        bypasses_before = bypass_count;
        seen_req        = '0;
        first_word      = '0;
        cycle           = 0;
        first_valid     = -1;
        stall_left      = idx % STALL_SPREAD;
        bus_requests    = 0;
        busy_cycles     = 0;
        taken           = 1'b0;

        fetch_req.addr  = addr;
        fetch_req.valid = 1'b1;
        fetch_rsp_ready = (stall_left == 0);
        @(posedge clock);
        while (!fetch_req_ready) begin
            @(posedge clock);
        end
        @(negedge clock);
        fetch_req.valid = 1'b0;

        // Cycles are counted from the accepting edge
        while (!taken) begin
            @(posedge clock);
            cycle++;
            if (bus_req.valid) begin
                busy_cycles++;
            end
            if (bus_req.valid && bus_req_ready) begin
                bus_requests++;
                seen_req = bus_req;
            end
            if (fetch_rsp.valid) begin
                if (first_valid < 0) begin
                    first_valid = cycle;
                    first_word  = fetch_rsp.data;
                end else if (fetch_rsp.data != first_word) begin
                    report_error($sformatf("response for %h changed while held", addr));
                end
                taken = fetch_rsp_ready;
            end
            @(negedge clock);
            if (first_valid >= 0 && stall_left > 0) begin
                stall_left--;
            end
            fetch_rsp_ready = !taken && (stall_left == 0);
        end

        check_count++;
        if (first_word != expect_word) begin
            report_error($sformatf("fetch %h returned %h, expected %h",
                                   addr, first_word, expect_word));
        end
        if (outcome == outcome_hit) begin
            if (first_valid != HIT_LATENCY || busy_cycles != 0) begin
                report_error($sformatf("hit at %h took %0d cycles with %0d bus cycles",
                                       addr, first_valid, busy_cycles));
            end
        end else if (outcome == outcome_miss) begin
            if (bus_requests != 1 || seen_req.len != REFILL_LEN ||
                seen_req.addr != (addr & ~icache_pkg::addr_t'(LINE_BYTES - 1))) begin
                report_error($sformatf("miss at %h gave %0d requests, last %h len %0d",
                                       addr, bus_requests, seen_req.addr, seen_req.len));
            end
        end else begin
            if (bus_requests != 1 || seen_req.len != '0 || seen_req.addr != addr) begin
                report_error($sformatf("bypass at %h gave %0d requests, last %h len %0d",
                                       addr, bus_requests, seen_req.addr, seen_req.len));
            end
        end

        // Exactly the matching counter steps
        if (hit_count != hits_before + icache_pkg::perf_count_t'(outcome == outcome_hit) ||
            miss_count != misses_before + icache_pkg::perf_count_t'(outcome == outcome_miss) ||
            bypass_count != bypasses_before +
                icache_pkg::perf_count_t'(outcome == outcome_bypass)) begin
            report_error($sformatf("counters after fetch %h are %0d %0d %0d",
                                   addr, hit_count, miss_count, bypass_count));
        end
    endtask

    task automatic check_totals();
        icache_pkg::perf_count_t want_hits;
        icache_pkg::perf_count_t want_misses;
        icache_pkg::perf_count_t want_bypasses;
        want_hits     = '0;
        want_misses   = '0;
        want_bypasses = '0;
        for (int i = 0; i < case_outcome.size(); i++) begin
            if (case_outcome[i] == outcome_hit) begin
                want_hits++;
            end else if (case_outcome[i] == outcome_miss) begin
                want_misses++;
            end else if (case_outcome[i] == outcome_bypass) begin
                want_bypasses++;
            end
        end
        check_count++;
        if (hit_count != want_hits || miss_count != want_misses ||
            bypass_count != want_bypasses) begin
            report_error($sformatf("totals %0d %0d %0d, expected %0d %0d %0d",
                                   hit_count, miss_count, bypass_count,
                                   want_hits, want_misses, want_bypasses));
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        flush           = 1'b0;
        fetch_req       = '0;
        fetch_rsp_ready = 1'b0;
        error_count     = 0;
        check_count     = 0;
        cases_loaded    = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        if (case_addr.size() == 0) begin
            $display("the cases file holds no operations");
            error_count++;
        end
        @(negedge reset);
        @(negedge clock);
        for (int i = 0; i < case_addr.size(); i++) begin
            if (case_is_flush[i]) begin
                apply_flush();
            end else begin
                run_fetch(i);
            end
        end
        @(negedge clock);
        check_totals();
        $display("checks %0d, errors %0d, hits %0d, misses %0d, bypasses %0d",
                 check_count, error_count, hit_count, miss_count, bypass_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized by the number of cases
    initial begin
        int limit;
        wait (cases_loaded);
        limit = RESET_CYCLES + CYCLES_PER_CASE * (case_addr.size() + 1);
        repeat (limit) @(posedge clock);
        $display("timeout: the test did not end within %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: bench/bus_memory_model.sv
`timescale 1ns/10ps

module bus_memory_model #(
    parameter logic [15:0] SEED = 16'd22
) (
    input  logic                 clock,
    input  logic                 reset,
    input  icache_pkg::bus_req_t bus_req,
    output logic                 bus_req_ready,
    output icache_pkg::bus_rsp_t bus_rsp
);

    localparam icache_pkg::word_t DATA_MASK = 32'h1234abcd;

    logic [15:0] lfsr_state;

    // Fibonacci form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // Random idle falling edges, one LFSR step per bit taken
    task automatic random_wait();
        lfsr_state = lfsr_next(lfsr_state);
        while (lfsr_state[0]) begin
            @(negedge clock);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic icache_pkg::word_t beat_data(input icache_pkg::addr_t addr);
        return {addr[31:2], 2'b00} ^ DATA_MASK;
    endfunction

    // ------------------------------
    // Address phase, then the beats
    // ------------------------------
    initial begin
        icache_pkg::addr_t beat_addr;
        int                beats;
        bus_req_ready = 1'b0;
        bus_rsp       = '0;
        lfsr_state    = SEED;
        forever begin
            @(negedge clock);
            if (!reset && bus_req.valid) begin
                random_wait();
                beat_addr     = bus_req.addr;
                beats         = int'(bus_req.len) + 1;
                bus_req_ready = 1'b1;
                @(negedge clock);
                bus_req_ready = 1'b0;
                // Incrementing burst, one word per beat
                for (int i = 0; i < beats; i++) begin
                    random_wait();
                    bus_rsp.valid = 1'b1;
                    bus_rsp.data  = beat_data(beat_addr + icache_pkg::addr_t'(4 * i));
                    bus_rsp.last  = (i == beats - 1);
                    @(negedge clock);
                    bus_rsp = '0;
                end
            end
        end
    end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    // Release on a falling edge, away from the flops
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/10ps

module icache_top #(
    parameter int INDEX_WIDTH     = 2,
    parameter int LINE_WORDS_LOG2 = 2,
    localparam int TAG_WIDTH      = icache_pkg::tag_width(INDEX_WIDTH, LINE_WORDS_LOG2)
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     flush,
    input  icache_pkg::fetch_req_t   fetch_req,
    output logic                     fetch_req_ready,
    output icache_pkg::fetch_rsp_t   fetch_rsp,
    input  logic                     fetch_rsp_ready,
    output icache_pkg::bus_req_t     bus_req,
    input  logic                     bus_req_ready,
    input  icache_pkg::bus_rsp_t     bus_rsp,
    output icache_pkg::perf_count_t  hit_count,
    output icache_pkg::perf_count_t  miss_count,
    output icache_pkg::perf_count_t  bypass_count
);

    // Controller to array
    logic [INDEX_WIDTH-1:0]     lookup_index;
    logic [TAG_WIDTH-1:0]       lookup_tag;
    logic [LINE_WORDS_LOG2-1:0] lookup_word_offset;
    logic                       lookup_hit;
    icache_pkg::word_t          lookup_word;
    logic                       refill_start;
    logic                       refill_word;
    logic [LINE_WORDS_LOG2-1:0] refill_offset;
    icache_pkg::word_t          refill_data;

    // Controller to counters
    logic hit_event;
    logic miss_event;
    logic bypass_event;

    icache_ctrl #(
        .INDEX_WIDTH     (INDEX_WIDTH),
        .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
    ) icache_ctrl_inst (
        .clock              (clock),
        .reset              (reset),
        .fetch_req          (fetch_req),
        .fetch_req_ready    (fetch_req_ready),
        .fetch_rsp          (fetch_rsp),
        .fetch_rsp_ready    (fetch_rsp_ready),
        .bus_req            (bus_req),
        .bus_req_ready      (bus_req_ready),
        .bus_rsp            (bus_rsp),
        .lookup_index       (lookup_index),
        .lookup_tag         (lookup_tag),
        .lookup_word_offset (lookup_word_offset),
        .lookup_hit         (lookup_hit),
        .lookup_word        (lookup_word),
        .refill_start       (refill_start),
        .refill_word        (refill_word),
        .refill_offset      (refill_offset),
        .refill_data        (refill_data),
        .hit_event          (hit_event),
        .miss_event         (miss_event),
        .bypass_event       (bypass_event)
    );

    icache_array #(
        .INDEX_WIDTH     (INDEX_WIDTH),
        .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
    ) icache_array_inst (
        .clock              (clock),
        .reset              (reset),
        .flush              (flush),
        .lookup_index       (lookup_index),
        .lookup_tag         (lookup_tag),
        .lookup_hit         (lookup_hit),
        .lookup_word_offset (lookup_word_offset),
        .lookup_word        (lookup_word),
        .refill_word        (refill_word),
        .refill_offset      (refill_offset),
        .refill_data        (refill_data),
        .refill_start       (refill_start)
    );

    icache_perf icache_perf_inst (
        .clock        (clock),
        .reset        (reset),
        .hit_event    (hit_event),
        .miss_event   (miss_event),
        .bypass_event (bypass_event),
        .hit_count    (hit_count),
        .miss_count   (miss_count),
        .bypass_count (bypass_count)
    );

endmodule

// File: rtl/icache_perf.sv
`timescale 1ns/10ps

module icache_perf (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     hit_event,
    input  logic                     miss_event,
    input  logic                     bypass_event,
    output icache_pkg::perf_count_t  hit_count,
    output icache_pkg::perf_count_t  miss_count,
    output icache_pkg::perf_count_t  bypass_count
);

    localparam int COUNTERS = 3;

    logic [COUNTERS-1:0]     events;
    icache_pkg::perf_count_t counts [COUNTERS];

    // Bit order matches the count outputs below
    assign events = {bypass_event, miss_event, hit_event};

    // ------------------------------
    // Saturating event counters
    // ------------------------------
    for (genvar i = 0; i < COUNTERS; i++) begin : gen_counter
        always_ff @(posedge clock or posedge reset) begin
            if (reset) begin
                counts[i] <= '0;
            end else if (events[i] && counts[i] != '1) begin
                counts[i] <= counts[i] + 1'b1;
            end
        end
    end

    assign hit_count    = counts[0];
    assign miss_count   = counts[1];
    assign bypass_count = counts[2];

    // At most one class per fetch, and never in the same cycle
    assert property (@(posedge clock) disable iff (reset)
        $onehot0(events))
        else $error("icache_perf: more than one event in a cycle");

    // A miss is always followed later by a fill, so no back-to-back misses
    assert property (@(posedge clock) disable iff (reset)
        miss_event |=> !miss_event)
        else $error("icache_perf: miss strobe longer than one cycle");

endmodule

// File: rtl/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl #(
    parameter int INDEX_WIDTH     = 2,
    parameter int LINE_WORDS_LOG2 = 2,
    localparam int TAG_WIDTH      = icache_pkg::tag_width(INDEX_WIDTH, LINE_WORDS_LOG2)
) (
    input  logic                       clock,
    input  logic                       reset,
    input  icache_pkg::fetch_req_t     fetch_req,
    output logic                       fetch_req_ready,
    output icache_pkg::fetch_rsp_t     fetch_rsp,
    input  logic                       fetch_rsp_ready,
    output icache_pkg::bus_req_t       bus_req,
    input  logic                       bus_req_ready,
    input  icache_pkg::bus_rsp_t       bus_rsp,
    output logic [INDEX_WIDTH-1:0]     lookup_index,
    output logic [TAG_WIDTH-1:0]       lookup_tag,
    output logic [LINE_WORDS_LOG2-1:0] lookup_word_offset,
    input  logic                       lookup_hit,
    input  icache_pkg::word_t          lookup_word,
    output logic                       refill_start,
    output logic                       refill_word,
    output logic [LINE_WORDS_LOG2-1:0] refill_offset,
    output icache_pkg::word_t          refill_data,
    output logic                       hit_event,
    output logic                       miss_event,
    output logic                       bypass_event
);

    localparam int OFFSET_LSB = icache_pkg::WORD_BYTE_BITS;
    localparam int INDEX_LSB  = OFFSET_LSB + LINE_WORDS_LOG2;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_WIDTH;
    localparam int ADDR_BITS  = $bits(icache_pkg::addr_t);
    localparam int REGION_BITS = $bits(icache_pkg::region_tag_t);
    localparam icache_pkg::burst_len_t REFILL_LEN =
        icache_pkg::burst_len_t'((1 << LINE_WORDS_LOG2) - 1);

    icache_pkg::cache_state_t    state;
    icache_pkg::cache_state_t    state_next;
    icache_pkg::addr_t           req_addr;
    icache_pkg::addr_t           line_addr;
    icache_pkg::region_tag_t     fetch_region;
    icache_pkg::word_t           captured_word;
    logic [LINE_WORDS_LOG2-1:0]  beat_count;
    logic                        fetch_cacheable;
    logic                        req_fire;
    logic                        rsp_fire;
    logic                        bus_valid;
    logic                        word_held;

    assign fetch_region    = fetch_req.addr[ADDR_BITS-1 -: REGION_BITS];
    assign fetch_cacheable = (fetch_region == icache_pkg::CACHEABLE_REGION);
    assign fetch_req_ready = (state == icache_pkg::state_idle);
    assign req_fire        = fetch_req.valid && fetch_req_ready;
    assign rsp_fire        = fetch_rsp.valid && fetch_rsp_ready;

    // Address fields of the accepted fetch
    assign lookup_index       = req_addr[TAG_LSB-1:INDEX_LSB];
    assign lookup_tag         = req_addr[ADDR_BITS-1:TAG_LSB];
    assign lookup_word_offset = req_addr[INDEX_LSB-1:OFFSET_LSB];
    assign line_addr          = {req_addr[ADDR_BITS-1:INDEX_LSB], {INDEX_LSB{1'b0}}};

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::state_idle: begin
                if (req_fire) begin
                    state_next = fetch_cacheable ? icache_pkg::state_lookup
                                                 : icache_pkg::state_bypass;
                end
            end
            icache_pkg::state_lookup: begin
                state_next = lookup_hit ? icache_pkg::state_hit_reply
                                        : icache_pkg::state_refill;
            end
            default: begin
                if (rsp_fire) begin
                    state_next = icache_pkg::state_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= icache_pkg::state_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (req_fire) begin
            req_addr <= fetch_req.addr;
        end
    end

    // Perf strobes and array writes
    assign hit_event     = (state == icache_pkg::state_lookup) && lookup_hit;
    assign miss_event    = refill_start;
    assign bypass_event  = req_fire && !fetch_cacheable;
    assign refill_start  = (state == icache_pkg::state_lookup) && !lookup_hit;
    assign refill_word   = (state == icache_pkg::state_refill) && bus_rsp.valid && !word_held;
    assign refill_offset = beat_count;
    assign refill_data   = bus_rsp.data;

    // ------------------------------
    // Bus request
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_valid <= 1'b0;
        end else if (refill_start || bypass_event) begin
            bus_valid <= 1'b1;
        end else if (bus_req_ready) begin
            bus_valid <= 1'b0;
        end
    end

    always_comb begin
        bus_req.valid = bus_valid;
        if (state == icache_pkg::state_refill) begin
            bus_req.addr = line_addr;
            bus_req.len  = REFILL_LEN;
        end else begin
            bus_req.addr = req_addr;
            bus_req.len  = '0;
        end
    end

    // Beat counter for the line words
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beat_count <= '0;
        end else if (refill_start) begin
            beat_count <= '0;
        end else if (refill_word) begin
            beat_count <= beat_count + 1'b1;
        end
    end

    // ------------------------------
    // Reply word capture
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            word_held <= 1'b0;
        end else if (state == icache_pkg::state_idle || rsp_fire) begin
            word_held <= 1'b0;
        end else if (state == icache_pkg::state_bypass && bus_rsp.valid) begin
            word_held <= 1'b1;
        end else if (refill_word && bus_rsp.last) begin
            word_held <= 1'b1;
        end
    end

    // Requested word as its beat passes
    always_ff @(posedge clock) begin
        if (refill_word && beat_count == lookup_word_offset) begin
            captured_word <= bus_rsp.data;
        end else if (state == icache_pkg::state_bypass && bus_rsp.valid && !word_held) begin
            captured_word <= bus_rsp.data;
        end
    end

    always_comb begin
        fetch_rsp.valid = 1'b0;
        fetch_rsp.data  = captured_word;
        case (state)
            icache_pkg::state_hit_reply: begin
                fetch_rsp.valid = 1'b1;
                fetch_rsp.data  = lookup_word;
            end
            icache_pkg::state_refill: begin
                fetch_rsp.valid = word_held;
            end
            icache_pkg::state_bypass: begin
                // Beat passes straight through unless already held
                fetch_rsp.valid = word_held || bus_rsp.valid;
                fetch_rsp.data  = word_held ? captured_word : bus_rsp.data;
            end
            default: begin
                fetch_rsp.valid = 1'b0;
            end
        endcase
    end

    assert property (@(posedge clock) disable iff (reset)
        bus_req.valid && !bus_req_ready |=> bus_req.valid && $stable(bus_req))
        else $error("icache_ctrl: bus request changed while waiting");

    // A new fetch never starts while a bus request is still pending
    assert property (@(posedge clock) disable iff (reset)
        req_fire |-> !bus_req.valid)
        else $error("icache_ctrl: fetch accepted while busy");

endmodule

// File: rtl/icache_array.sv
`timescale 1ns/10ps

module icache_array #(
    parameter int INDEX_WIDTH     = 2,
    parameter int LINE_WORDS_LOG2 = 2,
    localparam int TAG_WIDTH      = icache_pkg::tag_width(INDEX_WIDTH, LINE_WORDS_LOG2)
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic [INDEX_WIDTH-1:0]     lookup_index,
    input  logic [TAG_WIDTH-1:0]       lookup_tag,
    output logic                       lookup_hit,
    input  logic [LINE_WORDS_LOG2-1:0] lookup_word_offset,
    output icache_pkg::word_t          lookup_word,
    input  logic                       refill_word,
    input  logic [LINE_WORDS_LOG2-1:0] refill_offset,
    input  icache_pkg::word_t          refill_data,
    input  logic                       refill_start
);

    localparam int LINES = 1 << INDEX_WIDTH;
    localparam int WORDS = 1 << (INDEX_WIDTH + LINE_WORDS_LOG2);

    logic [LINES-1:0]     valid_bits;
    logic [TAG_WIDTH-1:0] line_tags [LINES];
    icache_pkg::word_t    line_data [WORDS];

    // ------------------------------
    // Valid bits
    // ------------------------------
    // Flush wins over a line being claimed
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (flush) begin
            valid_bits <= '0;
        end else if (refill_start) begin
            valid_bits[lookup_index] <= 1'b1;
        end
    end

    // ------------------------------
    // Tags and data words
    // ------------------------------
    always_ff @(posedge clock) begin
        if (refill_start) begin
            line_tags[lookup_index] <= lookup_tag;
        end
    end

    // One word per refill beat, line index held by the controller
    always_ff @(posedge clock) begin
        if (refill_word) begin
            line_data[{lookup_index, refill_offset}] <= refill_data;
        end
    end

    // Combinational lookup
    assign lookup_hit  = valid_bits[lookup_index] && (line_tags[lookup_index] == lookup_tag);
    assign lookup_word = line_data[{lookup_index, lookup_word_offset}];

    // Flush only comes while the cache is idle, so never during a refill
    assert property (@(posedge clock) disable iff (reset)
        !(refill_word && flush))
        else $error("icache_array: refill write during flush");

endmodule

// File: rtl/icache_pkg.sv
package icache_pkg;

    // ------------------------------
    // Widths with a meaning
    // ------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  region_tag_t;
    typedef logic [7:0]  burst_len_t;
    typedef logic [31:0] perf_count_t;

    // Top nibble of the cached address window
    localparam region_tag_t CACHEABLE_REGION = 4'ha;

    // Byte offset bits inside one word
    localparam int WORD_BYTE_BITS = 2;

    // Tag is what remains above index and line offset
    function automatic int tag_width(input int index_width, input int line_words_log2);
        return $bits(addr_t) - WORD_BYTE_BITS - line_words_log2 - index_width;
    endfunction

    // ------------------------------
    // Fetch side
    // ------------------------------
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } fetch_rsp_t;

    // ------------------------------
    // Memory bus side
    // ------------------------------
    // len counts beats minus one
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        burst_len_t len;
    } bus_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        state_idle,
        state_lookup,
        state_hit_reply,
        state_refill,
        state_bypass
    } cache_state_t;

endpackage
